// ==== logic/qpll_pkg.sv ====
// QPLL common block definitions
// DRP port widths and the layout of the control register window
`default_nettype none

package qpll_pkg;

  // ********************************************************************
  // DRP port

  localparam int drp_addr_w = 12;
  localparam int drp_data_w = 16;

  // ********************************************************************
  // Control register window

  // Width of the register index at the bottom of a control address
  localparam int ctrl_idx_w = 2;

  localparam logic [ctrl_idx_w-1:0] ctrl_idx_ctrl    = 2'd0;
  localparam logic [ctrl_idx_w-1:0] ctrl_idx_status  = 2'd1;
  localparam logic [ctrl_idx_w-1:0] ctrl_idx_scratch = 2'd2;

  // CTRL bit that holds the PLL in reset, set coming out of reset
  localparam int ctrl_rst_bit = 0;

  // STATUS bit that follows the PLL lock
  localparam int status_lock_bit = 0;

endpackage

`default_nettype wire

// ==== logic/wb_pkg.sv ====
// Wishbone slave definitions
// Bus widths and the two views of a decoded word address
`default_nettype none

package wb_pkg;

  // ********************************************************************
  // Bus widths

  localparam int wb_adr_w = 13;
  localparam int wb_dat_w = 16;

  // Top address bit selects the region, 1 for DRP and 0 for control
  localparam logic region_drp = 1'b1;

  // ********************************************************************
  // Decoded address
  // The same word reads as a DRP address or as a control register index

  typedef union packed {
    struct packed {
      logic                                     region;
      logic [qpll_pkg::drp_addr_w-1:0]          addr;
    } drp;
    struct packed {
      logic                                     region;
      logic [wb_adr_w-qpll_pkg::ctrl_idx_w-2:0] unused;
      logic [qpll_pkg::ctrl_idx_w-1:0]          idx;
    } ctrl;
  } wb_addr_u;

endpackage

`default_nettype wire

// ==== logic/drp_if.sv ====
// DRP interface
// One enable strobe per transaction, answered by a single ready pulse
`timescale 1ns/100ps
`default_nettype none

interface drp_if;

  logic                            sel;
  logic [qpll_pkg::drp_addr_w-1:0] addr;
  logic                            wr;
  logic [qpll_pkg::drp_data_w-1:0] wdata;
  logic [qpll_pkg::drp_data_w-1:0] rdata;
  logic                            ready;

  // Controller side, issues transactions
  modport master (
    output sel, addr, wr, wdata,
    input  rdata, ready
  );

  // Common block side, answers them
  modport slave (
    input  sel, addr, wr, wdata,
    output rdata, ready
  );

endinterface

`default_nettype wire

// ==== logic/qpll_common.sv ====
// QPLL common block model
// DRP register file with a fixed answer latency and a lock counter
`timescale 1ns/100ps
`default_nettype none

module qpll_common #(
  parameter int drp_depth   = 64,
  parameter int drp_latency = 3,
  parameter int lock_cycles = 20
) (
  input  logic up_clk,
  input  logic rst_n,
  input  logic qpll_rst,
  drp_if.slave drp,
  output logic qpll_locked
);

  localparam int idx_w = (drp_depth > 1) ? $clog2(drp_depth) : 1;
  localparam int cnt_w = $clog2(lock_cycles + 1);

  logic [qpll_pkg::drp_data_w-1:0] drp_mem [drp_depth];
  logic                            drp_hit;
  logic [idx_w-1:0]                drp_idx;
  logic [drp_latency-1:0]          drp_pend;
  logic [cnt_w-1:0]                lock_cnt;

  // ********************************************************************
  // DRP register file

  // Addresses past the implemented range are dropped and never answered
  assign drp_hit = drp.sel && (drp.addr < drp_depth);

  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < drp_depth; i++) begin
        drp_mem[i] <= '0;
      end
    end else if (drp_hit && drp.wr) begin
      drp_mem[drp.addr[idx_w-1:0]] <= drp.wdata;
    end
  end

  // Each accepted enable walks down the delay line and pops out as ready
  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      drp_pend <= '0;
    end else begin
      drp_pend <= (drp_pend << 1) | drp_latency'(drp_hit);
    end
  end

  always_ff @(posedge up_clk) begin
    if (drp_hit) begin
      drp_idx <= drp.addr[idx_w-1:0];
    end
  end

  assign drp.ready = drp_pend[drp_latency-1];
  // A write answers with the word just written
  assign drp.rdata = drp_mem[drp_idx];

  // ********************************************************************
  // Lock detect

  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_cnt <= '0;
    end else if (qpll_rst) begin
      lock_cnt <= '0;
    end else if (lock_cnt != cnt_w'(lock_cycles)) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  assign qpll_locked = (lock_cnt == cnt_w'(lock_cycles));

endmodule

`default_nettype wire

// ==== logic/wb_decode.sv ====
// Wishbone access decode
// Captures a new strobe as a registered request and stays busy until answered
`timescale 1ns/100ps
`default_nettype none

module wb_decode (
  input  logic                        up_clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [wb_pkg::wb_adr_w-1:0] wb_adr,
  input  logic [wb_pkg::wb_dat_w-1:0] wb_dat_w,
  input  logic                        resp_out,
  output logic                        req_valid,
  output logic                        req_we,
  output wb_pkg::wb_addr_u            req_addr,
  output logic [wb_pkg::wb_dat_w-1:0] req_wdata
);

  logic strobe;
  logic strobe_q;
  logic busy;
  logic accept;

  assign strobe = wb_cyc && wb_stb;

  // Only a rising strobe counts, the held strobe of a finished access does not
  assign accept = strobe && !strobe_q && !busy;

  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_q  <= 1'b0;
      busy      <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      strobe_q  <= strobe;
      req_valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_out) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (accept) begin
      req_we    <= wb_we;
      req_addr  <= wb_adr;
      req_wdata <= wb_dat_w;
    end
  end

  // One access in flight, so no request may start before the answer went out
  a_no_req_when_busy: assert property (
    @(posedge up_clk) disable iff (!rst_n) $rose(req_valid) |-> !$past(busy)
  ) else $error("wb_decode: request issued while an access is in flight");

endmodule

`default_nettype wire

// ==== logic/drp_execute.sv ====
// Request execution stage
// Control registers and the DRP transaction engine with its timeout
`timescale 1ns/100ps
`default_nettype none

module drp_execute #(
  parameter int drp_timeout = 16
) (
  input  logic                        up_clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  input  logic                        req_we,
  input  wb_pkg::wb_addr_u            req_addr,
  input  logic [wb_pkg::wb_dat_w-1:0] req_wdata,
  input  logic                        qpll_locked,
  drp_if.master                       drp,
  output logic                        qpll_rst,
  output logic                        done,
  output logic                        fail,
  output logic [wb_pkg::wb_dat_w-1:0] rdata
);

  localparam int tmr_w = $clog2(drp_timeout + 1);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]                  state;
  logic [tmr_w-1:0]            timer;
  logic                        is_drp;
  logic                        start;
  logic                        ctrl_rst;
  logic [wb_pkg::wb_dat_w-1:0] scratch;
  logic [wb_pkg::wb_dat_w-1:0] ctrl_word;
  logic [wb_pkg::wb_dat_w-1:0] status_word;
  logic [wb_pkg::wb_dat_w-1:0] ctrl_rdata;

  assign is_drp = (req_addr.drp.region == wb_pkg::region_drp);
  assign start  = req_valid && (state == st_idle);

  // ********************************************************************
  // Control register window

  always_comb begin
    ctrl_word = '0;
    ctrl_word[qpll_pkg::ctrl_rst_bit] = ctrl_rst;
    status_word = '0;
    status_word[qpll_pkg::status_lock_bit] = qpll_locked;
    case (req_addr.ctrl.idx)
      qpll_pkg::ctrl_idx_ctrl:    ctrl_rdata = ctrl_word;
      qpll_pkg::ctrl_idx_status:  ctrl_rdata = status_word;
      qpll_pkg::ctrl_idx_scratch: ctrl_rdata = scratch;
      default:                    ctrl_rdata = '0;
    endcase
  end

  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_rst <= 1'b1;
      scratch  <= '0;
    end else if (start && !is_drp && req_we) begin
      if (req_addr.ctrl.idx == qpll_pkg::ctrl_idx_ctrl) begin
        ctrl_rst <= req_wdata[qpll_pkg::ctrl_rst_bit];
      end
      if (req_addr.ctrl.idx == qpll_pkg::ctrl_idx_scratch) begin
        scratch <= req_wdata;
      end
    end
  end

  assign qpll_rst = ctrl_rst;

  // ********************************************************************
  // Transaction FSM
  // Control accesses go straight to done, DRP accesses wait for ready

  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      timer   <= '0;
      fail    <= 1'b0;
      drp.sel <= 1'b0;
    end else begin
      drp.sel <= 1'b0;
      case (state)
        st_idle: begin
          timer <= '0;
          if (req_valid) begin
            fail <= 1'b0;
            if (is_drp) begin
              drp.sel <= 1'b1;
              state   <= st_wait;
            end else begin
              state <= st_done;
            end
          end
        end
        st_wait: begin
          timer <= timer + 1'b1;
          if (drp.ready) begin
            state <= st_done;
          end else if (timer == tmr_w'(drp_timeout - 1)) begin
            // Nothing answers, give up and report an error
            fail  <= 1'b1;
            state <= st_done;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign done = (state == st_done);

  always_ff @(posedge up_clk) begin
    if (start) begin
      drp.addr  <= req_addr.drp.addr;
      drp.wr    <= req_we;
      drp.wdata <= req_wdata;
      rdata     <= ctrl_rdata;
    end else if ((state == st_wait) && drp.ready) begin
      rdata <= drp.rdata;
    end
  end

  a_sel_single: assert property (
    @(posedge up_clk) disable iff (!rst_n) drp.sel |=> !drp.sel
  ) else $error("drp_execute: DRP enable held longer than one cycle");

  // The common block may only answer a transaction that was issued
  a_no_ready_idle: assert property (
    @(posedge up_clk) disable iff (!rst_n) drp.ready |-> (state != st_idle)
  ) else $error("drp_execute: DRP ready without an outstanding transaction");

endmodule

`default_nettype wire

// ==== logic/wb_result.sv ====
// Wishbone response stage
// Registers read data and turns a done pulse into a single ack or err
`timescale 1ns/100ps
`default_nettype none

module wb_result (
  input  logic                        up_clk,
  input  logic                        rst_n,
  input  logic                        done,
  input  logic                        fail,
  input  logic [wb_pkg::wb_dat_w-1:0] rdata,
  output logic [wb_pkg::wb_dat_w-1:0] wb_dat_r,
  output logic                        wb_ack,
  output logic                        wb_err,
  output logic                        resp_out
);

  // Done is a single-cycle pulse, so each response lasts exactly one cycle
  always_ff @(posedge up_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      wb_ack <= done && !fail;
      wb_err <= done && fail;
    end
  end

  always_ff @(posedge up_clk) begin
    if (done) begin
      wb_dat_r <= rdata;
    end
  end

  // Decode may take the next strobe once the answer is on the bus
  assign resp_out = wb_ack || wb_err;

  a_ack_err_excl: assert property (
    @(posedge up_clk) disable iff (!rst_n) !(wb_ack && wb_err)
  ) else $error("wb_result: ack and err asserted together");

endmodule

`default_nettype wire

// ==== logic/gt_common_ctrl.sv ====
// Transceiver common block controller
// Wishbone slave driving the PLL control registers and DRP of the common block
`timescale 1ns/100ps
`default_nettype none

module gt_common_ctrl #(
  parameter int drp_depth   = 64,
  parameter int drp_latency = 3,
  parameter int drp_timeout = 16,
  parameter int lock_cycles = 20
) (
  input  logic                        up_clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [wb_pkg::wb_adr_w-1:0] wb_adr,
  input  logic [wb_pkg::wb_dat_w-1:0] wb_dat_w,
  output logic [wb_pkg::wb_dat_w-1:0] wb_dat_r,
  output logic                        wb_ack,
  output logic                        wb_err,
  output logic                        qpll_locked
);

  logic                        req_valid;
  logic                        req_we;
  wb_pkg::wb_addr_u            req_addr;
  logic [wb_pkg::wb_dat_w-1:0] req_wdata;
  logic                        done;
  logic                        fail;
  logic [wb_pkg::wb_dat_w-1:0] rdata;
  logic                        resp_out;
  logic                        qpll_rst;

  drp_if i_drp ();

  wb_decode i_wb_decode (
    .up_clk    (up_clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .resp_out  (resp_out),
    .req_valid (req_valid),
    .req_we    (req_we),
    .req_addr  (req_addr),
    .req_wdata (req_wdata)
  );

  drp_execute #(
    .drp_timeout (drp_timeout)
  ) i_drp_execute (
    .up_clk      (up_clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_we      (req_we),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .qpll_locked (qpll_locked),
    .drp         (i_drp.master),
    .qpll_rst    (qpll_rst),
    .done        (done),
    .fail        (fail),
    .rdata       (rdata)
  );

  wb_result i_wb_result (
    .up_clk   (up_clk),
    .rst_n    (rst_n),
    .done     (done),
    .fail     (fail),
    .rdata    (rdata),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .resp_out (resp_out)
  );

  // Behavioral stand-in for the vendor common primitive
  qpll_common #(
    .drp_depth   (drp_depth),
    .drp_latency (drp_latency),
    .lock_cycles (lock_cycles)
  ) i_qpll_common (
    .up_clk      (up_clk),
    .rst_n       (rst_n),
    .qpll_rst    (qpll_rst),
    .drp         (i_drp.slave),
    .qpll_locked (qpll_locked)
  );

endmodule

`default_nettype wire

// ==== tb/tb_gt_common_ctrl.sv ====
// Testbench for the transceiver common block controller
// Replays the accesses of the case file, then runs a random data pass
`timescale 1ns/100ps
`default_nettype none

module tb_gt_common_ctrl;

  localparam int bus_timeout = 100;
  localparam int poll_limit  = 50;
  localparam int rand_ops    = 40;

  logic        up_clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [12:0] wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        qpll_locked;

  int           fd;
  int           n;
  int           cases;
  int           idx;
  logic [191:0] name;
  logic [191:0] op;
  logic [191:0] resp;
  logic [1023:0] skip_line;
  logic [12:0]  adr;
  logic [15:0]  wdata;
  logic [15:0]  exp_rdata;
  logic [15:0]  rd;
  logic         got_err;
  logic         exp_err;
  logic [31:0]  seed_val;
  logic [15:0]  model [8];
  logic         written [8];

  gt_common_ctrl #(
    .drp_depth   (64),
    .drp_latency (3),
    .drp_timeout (16),
    .lock_cycles (20)
  ) DUT (
    .up_clk      (up_clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .wb_err      (wb_err),
    .qpll_locked (qpll_locked)
  );

  always #50 up_clk = ~up_clk;

  // ********************************************************************
  // Helpers

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [191:0] tname, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR: %0s expected %h actual %h", tname, expected, actual);
      abort_run();
    end
  endtask

  // Holds the strobe from a falling edge until ack or err shows up
  task automatic bus_access(input logic we, input logic [12:0] a, input logic [15:0] d,
                            output logic [15:0] data_out, output logic err_out);
    int cycles;
    cycles = 0;
    @(negedge up_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = a;
    wb_dat_w = d;
    @(negedge up_clk);
    while (!(wb_ack || wb_err) && (cycles < bus_timeout)) begin
      cycles++;
      @(negedge up_clk);
    end
    if (!(wb_ack || wb_err)) begin
      $display("Bus access to address %h got neither ack nor err in time", a);
      abort_run();
    end
    data_out = wb_dat_r;
    err_out  = wb_err;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
  endtask

  // Reads again until the expected word appears or the poll budget runs out
  task automatic poll_read(input logic [12:0] a, input logic [15:0] expected,
                           output logic [15:0] data_out, output logic err_out);
    int tries;
    tries = 0;
    bus_access(1'b0, a, 16'h0000, data_out, err_out);
    while ((data_out !== expected) && (tries < poll_limit)) begin
      tries++;
      bus_access(1'b0, a, 16'h0000, data_out, err_out);
    end
    if (data_out !== expected) begin
      $display("Polling address %h never returned %h within %0d reads", a, expected, tries);
      abort_run();
    end
  endtask

  // ********************************************************************
  // Main sequence

  initial begin
    up_clk   = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    cases    = 0;
    seed_val = $urandom(32'h7bcc_cfc2);
    repeat (3) @(posedge up_clk);
    @(negedge up_clk);
    rst_n = 1'b1;
    check_value("locked_reset", 32'd0, qpll_locked);

    fd = $fopen("tb/gt_common_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tb/gt_common_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", name);
      if (n == 1) begin
        if (name == "#") begin
          n = $fgets(skip_line, fd);
        end else begin
          n = $fscanf(fd, "%s %h %h %h %s", op, adr, wdata, exp_rdata, resp);
          if ((n != 5) || !((resp == "ack") || (resp == "err"))) begin
            $display("Malformed line in the case file at test %0s", name);
            abort_run();
          end
          cases++;
          exp_err = (resp == "err");
          if (op == "write") begin
            bus_access(1'b1, adr, wdata, rd, got_err);
          end else if (op == "read") begin
            bus_access(1'b0, adr, 16'h0000, rd, got_err);
          end else if (op == "poll") begin
            poll_read(adr, exp_rdata, rd, got_err);
          end else begin
            $display("Unknown operation %0s in test %0s", op, name);
            abort_run();
          end
          check_value(name, {31'd0, exp_err}, {31'd0, got_err});
          if ((op != "write") && !exp_err) begin
            check_value(name, {16'd0, exp_rdata}, {16'd0, rd});
          end
          // The lock output follows the STATUS lock bit
          if ((op != "write") && (adr == 13'h0001)) begin
            check_value(name, {31'd0, exp_rdata[0]}, {31'd0, qpll_locked});
          end
        end
      end
    end
    $fclose(fd);

    // ******************************************************************
    // Random pass over scratch (slot 0) and seven DRP words

    for (int i = 0; i < 8; i++) begin
      written[i] = 1'b0;
    end
    for (int i = 0; i < rand_ops; i++) begin
      idx = $urandom % 8;
      adr = (idx == 0) ? 13'h0002 : 13'h1000 + 13'(idx * 9);
      if (written[idx] && (($urandom % 2) == 1)) begin
        bus_access(1'b0, adr, 16'h0000, rd, got_err);
        check_value("random_read_resp", 32'd0, {31'd0, got_err});
        check_value("random_read_data", {16'd0, model[idx]}, {16'd0, rd});
      end else begin
        wdata = $urandom;
        bus_access(1'b1, adr, wdata, rd, got_err);
        check_value("random_write_resp", 32'd0, {31'd0, got_err});
        model[idx]   = wdata;
        written[idx] = 1'b1;
      end
    end

    if (cases > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("No accesses were read from the case file");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/qpll_pkg.sv
logic/wb_pkg.sv
logic/drp_if.sv
logic/qpll_common.sv
logic/wb_decode.sv
logic/drp_execute.sv
logic/wb_result.sv
logic/gt_common_ctrl.sv
tb/tb_gt_common_ctrl.sv

// ==== tb/gt_common_cases.txt ====
# name op addr wdata exp_rdata resp
# addr, wdata and exp_rdata are hex, op is write/read/poll, resp is ack or err
ctrl_reset      read  0000 0000 0001 ack
status_reset    read  0001 0000 0000 ack
drp5_reset      read  1005 0000 0000 ack
scratch_wr_a    write 0002 a5c3 0000 ack
scratch_rd_a    read  0002 0000 a5c3 ack
scratch_wr_b    write 0002 0ff0 0000 ack
scratch_rd_b    read  0002 0000 0ff0 ack
ctrl_wr_hold    write 0000 0001 0000 ack
ctrl_rd_hold    read  0000 0000 0001 ack
drp_wr_lo       write 1000 1234 0000 ack
drp_wr_hi       write 103f beef 0000 ack
drp_wr_5        write 1005 5a5a 0000 ack
drp_rd_lo       read  1000 0000 1234 ack
drp_rd_hi       read  103f 0000 beef ack
drp_rd_5        read  1005 0000 5a5a ack
drp_rd_oor      read  1040 0000 0000 err
drp_wr_oor      write 1fff 4321 0000 err
ctrl_wr_release write 0000 0000 0000 ack
ctrl_rd_release read  0000 0000 0000 ack
status_lock     poll  0001 0000 0001 ack
ctrl_wr_assert  write 0000 0001 0000 ack
status_unlock   read  0001 0000 0000 ack
